/* verilog/memPkg.sv */
package memPkg;

	// CPU address space as seen by the decoder
	typedef enum logic [1:0] {
		regionRam  = 2'b00, // A21 low
		regionRom  = 2'b01, // A21 high, A20 low
		regionNone = 2'b11  // Both high, nothing mapped
	} regionT;

	// Refresh timing, in CLK cycles
	localparam int RefPeriodDef = 2000; // One refresh window per period
	localparam int ReqWindowDef = 64;   // Request stays up this long
	localparam int UrgStartDef  = 32;   // Request turns urgent here

	// DTACK wait states per region
	localparam int RamWaitDef = 2;
	localparam int RomWaitDef = 4;

	// Region from the two top word-address bits
	function automatic regionT decodeRegion(
		input logic a21,
		input logic a20
	);
		regionT reg_;
		if (!a21) begin
			reg_ = regionRam;
		end else if (!a20) begin
			reg_ = regionRom;
		end else begin
			reg_ = regionNone;
		end
		return reg_;
	endfunction

endpackage

/* verilog/addrDecode.sv */
`timescale 1ns/1ps

module addrDecode (
	input  logic           CLK,
	input  logic           reset,
	input  logic [21:1]    A,
	input  logic           nAS,
	output logic           RAMCS,
	output logic           RAMCS0X,
	output logic           ROMCS,
	output memPkg::regionT region
);
	import memPkg::*;

	regionT rawRegion; // Region before the overlay
	logic   overlay;   // Boot ROM mirrored over RAM
	logic   asSeen;    // nAS was low at the last edge
	logic   romCycle;  // Current cycle targets ROM

	assign rawRegion = decodeRegion(A[21], A[20]);

	// Selects follow nAS directly
	assign RAMCS0X = !nAS && (rawRegion == regionRam);
	assign RAMCS   = RAMCS0X && !overlay; // Real RAM only once boot is done
	assign ROMCS   = !nAS && ((rawRegion == regionRom) ||
		(rawRegion == regionRam && overlay));

	// While the overlay is up, RAM space is timed like ROM
	always_comb begin
		if (overlay && rawRegion == regionRam) begin
			region = regionRom;
		end else begin
			region = rawRegion;
		end
	end

	// Overlay drops after the first real ROM cycle completes
	always_ff @(posedge CLK) begin
		if (reset) begin
			overlay  <= 1'b1;
			asSeen   <= 1'b0;
			romCycle <= 1'b0;
		end else begin
			asSeen <= !nAS;
			if (!nAS) begin
				romCycle <= (rawRegion == regionRom);
			end
			if (asSeen && nAS && romCycle) begin // Cycle just ended
				overlay <= 1'b0;
			end
		end
	end

endmodule

/* verilog/refreshTimer.sv */
`timescale 1ns/1ps

module refreshTimer #(
	parameter int RefPeriod = memPkg::RefPeriodDef,
	parameter int ReqWindow = memPkg::ReqWindowDef,
	parameter int UrgStart  = memPkg::UrgStartDef
) (
	input  logic CLK,
	input  logic reset,
	output logic RefReqIn,
	output logic RefUrgIn
);

	localparam int CntW = $clog2(RefPeriod);

	logic [CntW-1:0] refCnt;  // Position within the refresh period
	logic            lastCnt; // Final count before wrapping
	logic            inWindow;
	logic            pastUrg;

	assign lastCnt = (refCnt == CntW'(RefPeriod - 1));

	// Free-running, wraps at RefPeriod
	always_ff @(posedge CLK) begin
		if (reset) begin
			refCnt <= '0;
		end else if (lastCnt) begin
			refCnt <= '0;
		end else begin
			refCnt <= refCnt + 1'b1;
		end
	end

	// Request window opens at the wrap
	assign inWindow = (refCnt < CntW'(ReqWindow));
	assign pastUrg  = (refCnt >= CntW'(UrgStart));

	// Urgent window sits inside the request window
	assign RefReqIn = inWindow;
	assign RefUrgIn = inWindow && pastUrg;

endmodule

/* verilog/busCycle.sv */
`timescale 1ns/1ps

module busCycle #(
	parameter int RamWait = memPkg::RamWaitDef,
	parameter int RomWait = memPkg::RomWaitDef
) (
	input  logic           CLK,
	input  logic           reset,
	input  logic           nAS,
	input  memPkg::regionT region,
	input  logic           RAMReady,
	output logic           BACT,
	output logic           nDTACK
);
	import memPkg::*;

	localparam int MaxWait = (RamWait > RomWait) ? RamWait : RomWait;
	localparam int WaitW   = $clog2(MaxWait + 2);

	logic [WaitW-1:0] waitCnt;  // Edges seen with BACT high
	logic [WaitW-1:0] waitNeed; // Wait states for this region
	logic             waitDone;
	logic             dtackN;   // Registered DTACK, active low

	always_comb begin
		case (region)
			regionRam: waitNeed = WaitW'(RamWait);
			regionRom: waitNeed = WaitW'(RomWait);
			default:   waitNeed = '0; // Unmapped acks at once
		endcase
	end

	assign waitDone = (waitCnt >= waitNeed);

	always_ff @(posedge CLK) begin
		if (reset) begin
			BACT    <= 1'b0;
			waitCnt <= '0;
			dtackN  <= 1'b1;
		end else if (nAS) begin // No cycle, or cycle over
			BACT    <= 1'b0;
			waitCnt <= '0;
			dtackN  <= 1'b1;
		end else begin
			BACT <= 1'b1;
			if (BACT && waitCnt != WaitW'(MaxWait)) begin
				waitCnt <= waitCnt + 1'b1; // Saturates at the longest wait
			end
			// Refresh in progress holds DTACK off
			if (BACT && waitDone && RAMReady) begin
				dtackN <= 1'b0;
			end
		end
	end

	// Released the moment the CPU lets go of AS
	assign nDTACK = nAS || dtackN;

endmodule

/* verilog/dramCtl.sv */
`timescale 1ns/1ps

module dramCtl (
	input  logic        CLK,
	input  logic        reset,
	input  logic [21:1] A,
	input  logic        nWE,
	input  logic        nAS,
	input  logic        nLDS,
	input  logic        nUDS,
	input  logic        nDTACK,
	input  logic        BACT,
	input  logic        RAMCS,
	input  logic        RAMCS0X,
	input  logic        ROMCS,
	input  logic        RefReqIn,
	input  logic        RefUrgIn,
	output logic        RAMReady,
	output logic [11:0] RA,
	output logic        nRAS,
	output logic        nCAS,
	output logic        nLWE,
	output logic        nUWE,
	output logic        nOE,
	output logic        nROMCS,
	output logic        nROMWE
);

	localparam logic [2:0] stIdle     = 3'd0;
	localparam logic [2:0] stAccess   = 3'd1;
	localparam logic [2:0] stFinish   = 3'd2;
	localparam logic [2:0] stCycleEnd = 3'd3;
	localparam logic [2:0] stRefRas1  = 3'd4; // Refresh states all have bit 2 set
	localparam logic [2:0] stRefRas2  = 3'd5;
	localparam logic [2:0] stRefPre1  = 3'd6;
	localparam logic [2:0] stRefPre2  = 3'd7;

	logic [2:0]  state;
	logic        bactR;   // BACT one edge late
	logic        dtackR;  // DTACK seen, or cycle already ended
	logic        rasEn;   // Lets nAS drop RAS directly
	logic        rasOn;   // Registered RAS hold
	logic        colSel;  // Column address on RA
	logic        refDone; // Refresh already served this window
	logic        refReq;
	logic        refUrg;
	logic        toRef;
	logic [11:0] rowAddr;
	logic [11:0] colAddr;

	always_ff @(posedge CLK) begin
		if (reset) begin
			bactR  <= 1'b0;
			dtackR <= 1'b0;
		end else begin
			bactR  <= BACT;
			dtackR <= !nDTACK || (BACT && nAS); // Short DTACK may end with nAS
		end
	end

	// One refresh per window
	always_ff @(posedge CLK) begin
		if (reset) begin
			refDone <= 1'b0;
		end else if (!RefReqIn && !RefUrgIn) begin
			refDone <= 1'b0;
		end else if (state[2]) begin
			refDone <= 1'b1;
		end
	end

	assign refReq = RefReqIn && !refDone;
	assign refUrg = RefUrgIn && !refDone;

	// Polite refresh only at the start of a non-RAM cycle
	assign toRef = (refReq && BACT && !bactR && !RAMCS0X) ||
		(refUrg && !BACT) ||
		(refUrg && BACT && !RAMCS0X);

	always_ff @(posedge CLK) begin
		if (reset) begin
			state    <= stIdle;
			rasEn    <= 1'b1;
			rasOn    <= 1'b0;
			colSel   <= 1'b0;
			RAMReady <= 1'b1;
		end else begin
			case (state)
				stIdle: begin
					if (!nCAS) begin // CAS went down for CBR
						state    <= stRefRas1;
						rasEn    <= 1'b0;
						rasOn    <= 1'b1;
						RAMReady <= 1'b0;
					end else if (BACT && RAMCS && rasEn) begin
						state  <= stAccess;
						rasOn  <= 1'b1; // RAS already low through nAS
						colSel <= 1'b1;
					end
				end
				stAccess: begin
					state <= stFinish;
					rasEn <= 1'b0;
				end
				stFinish: begin
					colSel <= 1'b0;
					if (dtackR) begin
						state <= stCycleEnd;
						rasOn <= 1'b0;
					end
				end
				stCycleEnd: begin
					if (!nCAS) begin // Urgent refresh right behind the cycle
						state    <= stRefRas1;
						rasOn    <= 1'b1;
						RAMReady <= 1'b0;
					end else begin
						state <= stIdle;
						rasEn <= 1'b1;
					end
				end
				stRefRas1: state <= stRefRas2;
				stRefRas2: begin
					state <= stRefPre1;
					rasOn <= 1'b0;
				end
				stRefPre1: state <= stRefPre2;
				default: begin
					state    <= stIdle;
					rasEn    <= 1'b1;
					RAMReady <= 1'b1;
				end
			endcase
		end
	end

	// CAS moves on the falling edge
	always_ff @(negedge CLK) begin
		if (reset) begin
			nCAS <= 1'b1;
		end else begin
			case (state)
				stIdle:     nCAS <= !toRef; // Half a cycle ahead of refresh RAS
				stAccess:   nCAS <= 1'b0;
				stFinish:   nCAS <= dtackR;
				stCycleEnd: nCAS <= !refUrg;
				stRefRas1:  nCAS <= 1'b0;
				default:    nCAS <= 1'b1;
			endcase
		end
	end

	assign nRAS = !((rasEn && nCAS && RAMCS) || rasOn);

	// Early write, only with CAS down
	assign nLWE = !(!nLDS && !nWE && colSel && !nCAS);
	assign nUWE = !(!nUDS && !nWE && colSel && !nCAS);

	assign nROMCS = !ROMCS;
	assign nROMWE = !(!nAS && !nWE);

	// Shared OE for reads, drops the cycle after DTACK
	always_ff @(posedge CLK) begin
		if (reset) begin
			nOE <= 1'b1;
		end else begin
			nOE <= !(BACT && nWE && !(bactR && dtackR));
		end
	end

	// RA8 and RA11 double as flash A18 and A19 in the row half
	assign rowAddr = {A[19], A[17], A[15], A[18], A[14], A[13],
		A[12], A[11], A[19], A[16], A[10], A[9]};
	assign colAddr = {A[20], A[7], A[8], A[21], A[6], A[5],
		A[4], A[3], A[20], A[7], A[2], A[1]};
	assign RA = colSel ? colAddr : rowAddr;

endmodule

/* verilog/memCtl.sv */
`timescale 1ns/1ps

module memCtl #(
	parameter int RefPeriod = memPkg::RefPeriodDef,
	parameter int ReqWindow = memPkg::ReqWindowDef,
	parameter int UrgStart  = memPkg::UrgStartDef,
	parameter int RamWait   = memPkg::RamWaitDef,
	parameter int RomWait   = memPkg::RomWaitDef
) (
	input  logic        CLK,
	input  logic        reset,
	input  logic [21:1] A,
	input  logic        nAS,
	input  logic        nLDS,
	input  logic        nUDS,
	input  logic        nWE,
	output logic        nDTACK,
	output logic [11:0] RA,
	output logic        nRAS,
	output logic        nCAS,
	output logic        nLWE,
	output logic        nUWE,
	output logic        nOE,
	output logic        nROMCS,
	output logic        nROMWE
);
	import memPkg::*;

	logic   RAMCS;
	logic   RAMCS0X;
	logic   ROMCS;
	regionT region;
	logic   RefReqIn;
	logic   RefUrgIn;
	logic   BACT;
	logic   RAMReady; // Low while refresh owns the DRAM

	addrDecode uAddrDecode (
		.CLK(CLK), .reset(reset), .A(A), .nAS(nAS),
		.RAMCS(RAMCS), .RAMCS0X(RAMCS0X), .ROMCS(ROMCS), .region(region)
	);

	refreshTimer #(
		.RefPeriod(RefPeriod), .ReqWindow(ReqWindow), .UrgStart(UrgStart)
	) uRefreshTimer (
		.CLK(CLK), .reset(reset), .RefReqIn(RefReqIn), .RefUrgIn(RefUrgIn)
	);

	busCycle #(
		.RamWait(RamWait), .RomWait(RomWait)
	) uBusCycle (
		.CLK(CLK), .reset(reset), .nAS(nAS), .region(region),
		.RAMReady(RAMReady), .BACT(BACT), .nDTACK(nDTACK)
	);

	dramCtl uDramCtl (
		.CLK(CLK), .reset(reset), .A(A), .nWE(nWE), .nAS(nAS),
		.nLDS(nLDS), .nUDS(nUDS), .nDTACK(nDTACK), .BACT(BACT),
		.RAMCS(RAMCS), .RAMCS0X(RAMCS0X), .ROMCS(ROMCS),
		.RefReqIn(RefReqIn), .RefUrgIn(RefUrgIn), .RAMReady(RAMReady),
		.RA(RA), .nRAS(nRAS), .nCAS(nCAS), .nLWE(nLWE), .nUWE(nUWE),
		.nOE(nOE), .nROMCS(nROMCS), .nROMWE(nROMWE)
	);

endmodule

/* bench/memCtl_props.sv */
`timescale 1ns/1ps

module memCtl_props (
	input logic CLK,
	input logic reset,
	input logic nRAS,
	input logic nCAS,
	input logic nLWE,
	input logic nUWE,
	input logic nDTACK,
	input logic RAMReady
);

	// Write enables only inside a RAS and CAS access
	assert property (@(posedge CLK) disable iff (reset)
		(!nLWE || !nUWE) |-> (!nCAS && !nRAS))
	else $error("write enable low outside an access with nRAS and nCAS low");

	// CBR refresh holds RAS for two cycles
	assert property (@(posedge CLK) disable iff (reset)
		($fell(nRAS) && !nCAS) |=> !nRAS ##1 nRAS)
	else $error("refresh nRAS low time is not two cycles");

	// DTACK only starts when the DRAM side is ready
	assert property (@(posedge CLK) disable iff (reset)
		$fell(nDTACK) |-> $past(RAMReady))
	else $error("nDTACK fell while RAMReady was low");

endmodule

/* bench/memCtlTb.sv */
`timescale 1ns/1ps

module memCtlTb;

	localparam int RefPer     = 200;
	localparam int NumFixed   = 6;
	localparam int NumEntries = 16;
	localparam int Period     = 8;

	logic        CLK;
	logic        reset;
	logic [21:1] A;
	logic        nAS, nLDS, nUDS, nWE;
	logic        nDTACK, nRAS, nCAS, nLWE, nUWE, nOE, nROMCS, nROMWE;
	logic [11:0] RA;

	string       names[NumEntries];
	logic [21:1] addrs[NumEntries];
	bit          isWrite[NumEntries];
	bit          lowOn[NumEntries];  // Lower byte strobe active
	bit          upOn[NumEntries];
	int          gaps[NumEntries];   // Idle cycles before the entry

	bit          running = 0;
	bit          overlayModel;
	bit          accessCasLow = 0;
	bit          lweSeen, uweSeen, oeSeen;
	int          refreshCount = 0;
	int          accessRasCount;
	logic [11:0] rowSeen, colSeen;
	time         casFallTime = 0;
	time         rasFallTime = 0;
	time         startTime;

	memCtl #(.RefPeriod(RefPer), .ReqWindow(24), .UrgStart(12)) i_dut (
		.CLK(CLK), .reset(reset), .A(A), .nAS(nAS), .nLDS(nLDS), .nUDS(nUDS),
		.nWE(nWE), .nDTACK(nDTACK), .RA(RA), .nRAS(nRAS), .nCAS(nCAS),
		.nLWE(nLWE), .nUWE(nUWE), .nOE(nOE), .nROMCS(nROMCS), .nROMWE(nROMWE)
	);

	bind dramCtl memCtl_props uProps (
		.CLK(CLK), .reset(reset), .nRAS(nRAS), .nCAS(nCAS), .nLWE(nLWE),
		.nUWE(nUWE), .nDTACK(nDTACK), .RAMReady(RAMReady)
	);

	initial begin
		CLK = 1'b0;
		forever #(Period / 2) CLK = !CLK;
	end

	task automatic checkEqual(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		if (expVal !== actVal) begin
			$display("[ERROR] %s expected %0h actual %0h", name, expVal, actVal);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic setEntry(input int i, input string name, input logic [21:1] addr,
		input bit write);
		names[i]   = name;
		addrs[i]   = addr;
		isWrite[i] = write;
	endtask

	// DRAM row and column bit order from the board's address mapping
	function automatic logic [11:0] rowAddress(input logic [21:1] a);
		int          src[12];
		logic [11:0] ra;
		src = '{19, 17, 15, 18, 14, 13, 12, 11, 19, 16, 10, 9}; // RA11 first
		for (int k = 0; k < 12; k++) begin
			ra[11 - k] = a[src[k]];
		end
		return ra;
	endfunction

	function automatic logic [11:0] columnAddress(input logic [21:1] a);
		int          src[12];
		logic [11:0] ra;
		src = '{20, 7, 8, 21, 6, 5, 4, 3, 20, 7, 2, 1}; // RA11 first
		for (int k = 0; k < 12; k++) begin
			ra[11 - k] = a[src[k]];
		end
		return ra;
	endfunction

	// RAS fall monitor with a glitch filter
	always @(negedge nRAS) begin
		if (running) begin
			rasFallTime = $time;
			#1;
			if (!nRAS && !nCAS) begin // CBR refresh
				refreshCount++;
				checkEqual("refresh CAS before RAS", 1, casFallTime < rasFallTime);
				checkEqual("refresh inside RAM CAS", 0, accessCasLow);
			end else if (!nRAS) begin
				accessRasCount++;
				rowSeen = RA;
			end
		end
	end

	always @(negedge nCAS) begin
		if (running) begin
			casFallTime = $time;
			#1;
			if (!nCAS && !nRAS) begin // Access column strobe
				accessCasLow = 1;
				colSeen = RA;
			end
		end
	end

	always @(posedge nCAS) accessCasLow = 0;
	always @(negedge nLWE) if (running) lweSeen = 1;
	always @(negedge nUWE) if (running) uweSeen = 1;
	always @(negedge nOE) if (running) oeSeen = 1;

	task automatic runEntry(input int i);
		bit isRom;
		bit isRam;
		bit realRam;
		isRom   = addrs[i][21] && !addrs[i][20];
		isRam   = !addrs[i][21];
		realRam = isRam && !overlayModel;
		repeat (gaps[i]) @(negedge CLK);
		lweSeen = 0;
		uweSeen = 0;
		oeSeen = 0;
		accessRasCount = 0;
		A    = addrs[i];
		nWE  = !isWrite[i];
		nLDS = !lowOn[i];
		nUDS = !upOn[i];
		nAS  = 1'b0;
		do @(negedge CLK); while (nDTACK); // Wait for DTACK
		checkEqual({names[i], " nROMCS"}, !(isRom || (isRam && overlayModel)), nROMCS);
		if (isRom) begin
			checkEqual({names[i], " RA8"}, A[18], RA[8]);
			checkEqual({names[i], " RA11"}, A[19], RA[11]);
			checkEqual({names[i], " nROMWE"}, !isWrite[i], nROMWE);
		end
		nAS = 1'b1;
		@(negedge CLK);
		nWE  = 1'b1;
		nLDS = 1'b1;
		nUDS = 1'b1;
		repeat (3) @(negedge CLK); // Let the controller settle
		checkEqual({names[i], " access RAS count"}, realRam, accessRasCount);
		if (realRam) begin
			checkEqual({names[i], " row"}, rowAddress(addrs[i]), rowSeen);
			checkEqual({names[i], " column"}, columnAddress(addrs[i]), colSeen);
		end
		checkEqual({names[i], " nLWE low"}, realRam && isWrite[i] && lowOn[i], lweSeen);
		checkEqual({names[i], " nUWE low"}, realRam && isWrite[i] && upOn[i], uweSeen);
		checkEqual({names[i], " nOE low"}, !isWrite[i], oeSeen);
		if (isRom) overlayModel = 0; // First ROM cycle ends the boot overlay
	endtask

	initial begin
		int seedDummy;
		int expRef;
		longint cycles;
		seedDummy = $urandom(32'hfc83a1af);
		reset = 1'b1;
		A = '0;
		nAS = 1'b1;
		nLDS = 1'b1;
		nUDS = 1'b1;
		nWE = 1'b1;
		setEntry(0, "overlay ram read", 21'h012345, 0);
		setEntry(1, "rom read", 21'h13A5C3, 0);
		setEntry(2, "rom write", 21'h15A3E1, 1);
		setEntry(3, "ram write both", 21'h0ABCDE, 1);
		setEntry(4, "ram write lower", 21'h055AA1, 1);
		setEntry(5, "ram read", 21'h0F0F0F, 0);
		for (int i = 0; i < NumFixed; i++) begin
			lowOn[i] = 1;
			upOn[i]  = (i != 4);
			gaps[i]  = 2;
		end
		for (int i = NumFixed; i < NumEntries; i++) begin
			names[i]   = $sformatf("random ram %0d", i);
			addrs[i]   = {1'b0, 20'($urandom)};
			isWrite[i] = $urandom % 2;
			lowOn[i]   = $urandom % 2;
			upOn[i]    = !lowOn[i] || ($urandom % 2); // At least one strobe
			gaps[i]    = 1 + $urandom % 30;
		end
		overlayModel = 1;
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;
		startTime = $time;
		@(negedge CLK);
		checkEqual("reset pins", 7'h7F, {nRAS, nCAS, nLWE, nUWE, nOE, nROMWE, nDTACK});
		running = 1;
		for (int i = 0; i < NumEntries; i++) begin
			runEntry(i);
		end
		repeat (3 * RefPer) @(negedge CLK); // Idle refreshes
		cycles = ($time - startTime) / Period;
		expRef = cycles / RefPer;
		if (refreshCount > expRef + 1 || refreshCount < expRef - 1) begin
			checkEqual("refresh count", expRef, refreshCount);
		end else begin
			$display("No errors");
			$finish;
		end
	end

	// Watchdog sized from the table and the refresh period
	initial begin
		#((NumEntries * 40 + 20 * RefPer + 16) * Period);
		$display("Errors found");
		$display("Timeout: the run did not finish in time");
		$fatal(1);
	end

endmodule

/* memCtl.f */
verilog/memPkg.sv
verilog/addrDecode.sv
verilog/refreshTimer.sv
verilog/busCycle.sv
verilog/dramCtl.sv
verilog/memCtl.sv
bench/memCtl_props.sv
bench/memCtlTb.sv
